// ==== include/audio_macros.svh ====
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// audio_clk cycles per half bit clock
`define BCLK_DIV 4

// Bit clocks per I2S frame, half per slot
`define FRAME_BITS 64

// Bits the microphone drives per slot, top 16 kept
`define MIC_BITS 24

// Delay buffer entries
`define DELAY_DEPTH 256

// DC tracking filter shift
`define DC_SHIFT 6

`endif

// ==== logic/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

  // One sample and its strobe
  typedef struct packed {
    logic               valid;  // One-cycle pulse
    logic signed [15:0] data;
  } audio_sample_t;

  // Speaker source
  typedef enum logic [1:0] {
    SEL_RAW     = 2'd0,
    SEL_COND    = 2'd1,
    SEL_DELAYED = 2'd2,
    SEL_ECHO    = 2'd3  // Half of conditioned plus delayed
  } out_sel_e;

  // Receiver slot state
  typedef enum logic [1:0] {
    SLOT_IDLE  = 2'd0,  // Waiting for first ws fall
    SLOT_LEFT  = 2'd1,
    SLOT_RIGHT = 2'd2
  } i2s_slot_e;

endpackage

`default_nettype wire

// ==== logic/i2s_mic_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "audio_macros.svh"

module i2s_mic_rx import audio_pkg::*; (
  input  wire           audio_clk,
  input  wire           arst_n,
  input  wire           mic_data,
  output logic          bclk,
  output logic          ws,
  output audio_sample_t raw_sample
);

  localparam int DIV_W      = $clog2(`BCLK_DIV);
  localparam int HALF_FRAME = `FRAME_BITS / 2;
  localparam int LAST_BIT   = 16;

  logic [DIV_W-1:0]   div_cnt;
  logic [5:0]         bit_cnt;
  logic [5:0]         bit_cnt_next;
  i2s_slot_e          slot;
  logic               tick;
  logic               rise;
  logic               fall;
  logic               capture;
  logic               last_bit;
  logic [14:0]        shift_q;
  logic [15:0]        shift_next;
  logic               valid_q;
  logic signed [15:0] data_q;

  assign tick         = (div_cnt == DIV_W'(`BCLK_DIV - 1));
  assign rise         = tick && !bclk;
  assign fall         = tick && bclk;
  assign bit_cnt_next = (bit_cnt == 6'(`FRAME_BITS - 1)) ? 6'd0 : bit_cnt + 6'd1;

  // Bit 0 is the I2S offset bit, MSB arrives at bit 1
  assign capture    = rise && (slot == SLOT_LEFT) && (bit_cnt != 6'd0) &&
                      (bit_cnt <= 6'(LAST_BIT));
  assign last_bit   = capture && (bit_cnt == 6'(LAST_BIT));
  assign shift_next = {shift_q, mic_data};

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      bclk    <= 1'b0;
      bit_cnt <= '0;
      ws      <= 1'b0;
      slot    <= SLOT_IDLE;
      valid_q <= 1'b0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + DIV_W'(1);
      if (tick) begin
        bclk <= !bclk;
      end
      if (fall) begin  // ws moves with falling bclk
        bit_cnt <= bit_cnt_next;
        ws      <= (bit_cnt_next >= 6'(HALF_FRAME));
        if (bit_cnt_next == 6'd0) begin
          slot <= SLOT_LEFT;
        end else if (bit_cnt_next == 6'(HALF_FRAME) && slot == SLOT_LEFT) begin
          slot <= SLOT_RIGHT;
        end
      end
      valid_q <= last_bit;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (capture) begin
      shift_q <= shift_next[14:0];
    end
    if (last_bit) begin
      data_q <= shift_next;
    end
  end

  assign raw_sample = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// ==== logic/mic_conditioner.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "audio_macros.svh"

module mic_conditioner import audio_pkg::*; (
  input  wire           audio_clk,
  input  wire           arst_n,
  input  wire audio_sample_t raw_sample,
  output audio_sample_t cond_sample
);

  logic signed [23:0] avg_q;     // 16.8 fixed point
  logic signed [24:0] in_fix;
  logic signed [24:0] fix_diff;
  logic signed [24:0] step;
  logic signed [16:0] int_diff;
  logic signed [15:0] sat_diff;
  logic               valid_q;
  logic signed [15:0] data_q;

  assign in_fix   = {raw_sample.data[15], raw_sample.data, 8'd0};
  assign fix_diff = in_fix - {avg_q[23], avg_q};
  assign step     = fix_diff >>> `DC_SHIFT;

  // Input minus integer part of the average
  assign int_diff = {raw_sample.data[15], raw_sample.data} - {avg_q[23], avg_q[23:8]};

  always_comb begin
    if (int_diff[16] != int_diff[15]) begin
      sat_diff = int_diff[16] ? 16'sh8000 : 16'sh7fff;
    end else begin
      sat_diff = int_diff[15:0];
    end
  end

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      avg_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= raw_sample.valid;
      if (raw_sample.valid) begin
        avg_q <= avg_q + step[23:0];  // Leaky integrator toward input
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (raw_sample.valid) begin
      data_q <= sat_diff;
    end
  end

  assign cond_sample = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// ==== logic/sample_delay.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "audio_macros.svh"

module sample_delay import audio_pkg::*; (
  input  wire                audio_clk,
  input  wire                arst_n,
  input  wire [7:0]          delay_length,
  input  wire audio_sample_t in_sample,
  output audio_sample_t      out_sample
);

  localparam int PTR_W = $clog2(`DELAY_DEPTH);

  logic signed [15:0] mem [`DELAY_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W-1:0]   fill_cnt;   // Samples written, saturating
  logic               history_ok;
  logic               valid_q;
  logic signed [15:0] data_q;

  assign rd_ptr     = wr_ptr - delay_length;
  assign history_ok = (fill_cnt >= delay_length);

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= in_sample.valid;
      if (in_sample.valid) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
        if (fill_cnt != '1) begin
          fill_cnt <= fill_cnt + PTR_W'(1);
        end
      end
    end
  end

  // Read sees the old entry, write lands this cycle
  always_ff @(posedge audio_clk) begin
    if (in_sample.valid) begin
      mem[wr_ptr] <= in_sample.data;
      if (!history_ok) begin
        data_q <= '0;  // Not enough history yet
      end else if (delay_length == 8'd0) begin
        data_q <= in_sample.data;
      end else begin
        data_q <= mem[rd_ptr];
      end
    end
  end

  assign out_sample = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// ==== logic/pdm_modulator.sv ====
`timescale 1ns/10ps
`default_nettype none

module pdm_modulator (
  input  wire               audio_clk,
  input  wire               arst_n,
  input  wire signed [15:0] level,
  output logic              pdm
);

  logic [15:0] acc;
  logic [15:0] level_u;
  logic [16:0] sum;

  // Offset binary so -32768 maps to zero density
  assign level_u = level ^ 16'h8000;
  assign sum     = {1'b0, acc} + {1'b0, level_u};

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
      pdm <= 1'b0;
    end else begin
      acc <= sum[15:0];
      pdm <= sum[16];  // Carry out
    end
  end

endmodule

`default_nettype wire

// ==== logic/echo_path_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module echo_path_top import audio_pkg::*; (
  input  wire           audio_clk,
  input  wire           arst_n,
  input  wire           mic_data,
  input  wire out_sel_e out_sel,
  input  wire [7:0]     delay_length,
  input  wire           spk_en,
  output logic          bclk,
  output logic          ws,
  output logic          spk_pdm,
  output audio_sample_t monitor_sample
);

  audio_sample_t      raw_sample;
  audio_sample_t      cond_sample;
  audio_sample_t      delayed_sample;
  logic signed [15:0] raw_hold;
  logic signed [15:0] cond_hold;
  logic signed [16:0] echo_sum;
  logic signed [15:0] sel_data;
  logic               mon_valid;
  logic signed [15:0] mon_data;
  logic               pdm_bit;

  i2s_mic_rx u_mic_rx (
    .audio_clk  (audio_clk),
    .arst_n     (arst_n),
    .mic_data   (mic_data),
    .bclk       (bclk),
    .ws         (ws),
    .raw_sample (raw_sample)
  );

  mic_conditioner u_conditioner (
    .audio_clk   (audio_clk),
    .arst_n      (arst_n),
    .raw_sample  (raw_sample),
    .cond_sample (cond_sample)
  );

  sample_delay u_delay (
    .audio_clk    (audio_clk),
    .arst_n       (arst_n),
    .delay_length (delay_length),
    .in_sample    (cond_sample),
    .out_sample   (delayed_sample)
  );

  // Raw and conditioned values held until the delay output arrives
  always_ff @(posedge audio_clk) begin
    if (raw_sample.valid) begin
      raw_hold <= raw_sample.data;
    end
    if (cond_sample.valid) begin
      cond_hold <= cond_sample.data;
    end
  end

  assign echo_sum = {cond_hold[15], cond_hold} + {delayed_sample.data[15], delayed_sample.data};

  always_comb begin
    case (out_sel)
      SEL_RAW:     sel_data = raw_hold;
      SEL_COND:    sel_data = cond_hold;
      SEL_DELAYED: sel_data = delayed_sample.data;
      SEL_ECHO:    sel_data = echo_sum[16:1];  // Arithmetic half
      default:     sel_data = raw_hold;
    endcase
  end

  always_ff @(posedge audio_clk or negedge arst_n) begin
    if (!arst_n) begin
      mon_valid <= 1'b0;
      mon_data  <= '0;  // Speaker idles at midscale
    end else begin
      mon_valid <= delayed_sample.valid;
      if (delayed_sample.valid) begin
        mon_data <= sel_data;
      end
    end
  end

  assign monitor_sample = '{valid: mon_valid, data: mon_data};

  pdm_modulator u_pdm (
    .audio_clk (audio_clk),
    .arst_n    (arst_n),
    .level     (monitor_sample.data),
    .pdm       (pdm_bit)
  );

  assign spk_pdm = spk_en & pdm_bit;

endmodule

`default_nettype wire

// ==== tb/mic_model.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "audio_macros.svh"

module mic_model import audio_pkg::*; (
  input  wire               arst_n,
  input  wire               bclk,
  input  wire               ws,
  input  wire signed [15:0] word,
  output logic [9:0]        frame_idx,
  output logic              mic_data
);

  localparam int PAD_BITS = `MIC_BITS - 16;

  i2s_slot_e            slot;
  logic                 last_ws;
  logic [`MIC_BITS-1:0] shreg;  // Word then random pad, MSB first

  // ws is stable on rising bclk
  always @(posedge bclk or negedge arst_n) begin
    if (!arst_n) begin
      slot      <= SLOT_IDLE;
      last_ws   <= 1'b0;
      shreg     <= '0;
      frame_idx <= '0;
    end else begin
      last_ws <= ws;
      if (!ws && last_ws) begin  // Offset bit of a left slot
        slot      <= SLOT_LEFT;
        shreg     <= {word, PAD_BITS'($urandom)};
        frame_idx <= frame_idx + 10'd1;
      end else begin
        shreg <= shreg << 1;  // Zeros follow the pad
        if (ws && slot == SLOT_LEFT) begin
          slot <= SLOT_RIGHT;
        end
      end
    end
  end

  always @(negedge bclk or negedge arst_n) begin
    if (!arst_n) begin
      mic_data <= 1'b0;
    end else begin
      mic_data <= (slot == SLOT_LEFT) ? shreg[`MIC_BITS-1] : 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_echo_path.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "audio_macros.svh"

module tb_echo_path import audio_pkg::*; ();

  localparam int FRAME_CYCLES = `FRAME_BITS * 2 * `BCLK_DIV;

  logic               audio_clk;
  logic               arst_n;
  logic               mic_data;
  out_sel_e           out_sel;
  logic [7:0]         delay_length;
  logic               spk_en;
  logic               bclk;
  logic               ws;
  logic               spk_pdm;
  audio_sample_t      monitor_sample;
  logic signed [15:0] mic_word;
  logic [9:0]         frame_idx;
  logic signed [15:0] stream [1024];  // Mic words in frame order since reset
  int                 mon_idx;
  int                 test_err;
  int                 tests_ok;
  int                 tests_bad;
  logic               aborted;
  int                 pin_cycles;  // audio_clk edges since reset release
  int                 pin_err;

  echo_path_top u_echo_path_top (.*);

  mic_model u_mic (
    .arst_n    (arst_n),
    .bclk      (bclk),
    .ws        (ws),
    .word      (mic_word),
    .frame_idx (frame_idx),
    .mic_data  (mic_data)
  );

  assign mic_word = stream[frame_idx];

  always #5 audio_clk = ~audio_clk;

  // Mean moves by 1/64 of the error per sample
  function automatic int cond_ref(int j);
    int avg;
    int x;
    int y;
    avg = 0;
    y   = 0;
    for (int k = 0; k <= j; k++) begin
      x   = int'(stream[k[9:0]]);
      y   = x - (avg >>> 8);
      avg = avg + ((x * 256 - avg) >>> 6);
    end
    return (y > 32767) ? 32767 : ((y < -32768) ? -32768 : y);
  endfunction

  function automatic int expect_ref(out_sel_e sel, int j, int d);
    int delayed;
    delayed = (j >= d) ? cond_ref(j - d) : 0;  // Short history reads as zero
    case (sel)
      SEL_RAW:     return int'(stream[j[9:0]]);
      SEL_COND:    return cond_ref(j);
      SEL_DELAYED: return delayed;
      default:     return (cond_ref(j) + delayed) >>> 1;
    endcase
  endfunction

  // Levels of bclk and ws after a number of audio_clk edges from reset
  function automatic logic [1:0] pins_ref(int edges);
    int bits;
    bits = edges / (2 * `BCLK_DIV);  // Falling bclk edges so far
    return {1'((edges / `BCLK_DIV) % 2), 1'((bits % `FRAME_BITS) >= `FRAME_BITS / 2)};
  endfunction

  task automatic check_sample(string name, audio_sample_t exp, audio_sample_t act);
    if (exp !== act) begin
      $display("ERROR %s sample %0d: expected valid=%0b data=%0d, actual valid=%0b data=%0d",
               name, mon_idx, exp.valid, exp.data, act.valid, act.data);
      test_err++;
    end
  endtask

  task automatic check_density(string name, int exp, int act, int tol);
    if (act < exp - tol || act > exp + tol) begin
      $display("ERROR %s: expected %0d (within %0d), actual %0d", name, exp, tol, act);
      test_err++;
    end
  endtask

  task automatic check_pins(logic [1:0] exp);
    if ({bclk, ws} !== exp) begin
      $display("ERROR pin_timing edge %0d: expected bclk=%0b ws=%0b, actual bclk=%0b ws=%0b",
               pin_cycles, exp[1], exp[0], bclk, ws);
      pin_err++;
    end
  endtask

  task automatic finish_test(string name);
    if (test_err == 0 && !aborted) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d mismatches", name, test_err);
    end
    test_err = 0;
  endtask

  task automatic fill_stream(int first, int last, int base, int spread);
    for (int k = first; k <= last; k++) begin
      stream[k[9:0]] = 16'(base + int'($urandom % spread) - spread / 2);
    end
  endtask

  task automatic apply_reset();
    arst_n  = 1'b0;
    mon_idx = 0;
    repeat (8) @(negedge audio_clk);
    arst_n = 1'b1;
  endtask

  task automatic run_segment(string name, out_sel_e sel, int d, int count);
    int            cycles;
    audio_sample_t exp;
    out_sel      = sel;
    delay_length = 8'(d);
    for (int n = 0; n < count && !aborted; n++) begin
      cycles = 0;
      do begin
        @(negedge audio_clk);
        cycles++;
      end while (!monitor_sample.valid && cycles < 2000);
      if (!monitor_sample.valid) begin
        $display("%s: no monitor sample arrived within 2000 cycles", name);
        aborted = 1'b1;
      end else begin
        exp = '{valid: 1'b1, data: 16'(expect_ref(sel, mon_idx, d))};
        check_sample(name, exp, monitor_sample);
        if (sel == SEL_RAW && n > 0) begin
          check_density({name, " frame period"}, FRAME_CYCLES, cycles, 0);
        end
        mon_idx++;
      end
    end
    finish_test(name);
  endtask

  task automatic measure_density(string name, logic en, int cycles, int exp, int tol);
    int ones;
    ones   = 0;
    spk_en = en;
    for (int n = 0; n < cycles && !aborted; n++) begin
      @(negedge audio_clk);
      ones += int'(spk_pdm);
    end
    check_density(name, exp, ones, tol);
    finish_test(name);
  endtask

  always @(posedge audio_clk) begin
    pin_cycles <= arst_n ? pin_cycles + 1 : 0;
  end

  // Pins are stable between rising edges
  always @(negedge audio_clk) begin
    if (arst_n) begin
      check_pins(pins_ref(pin_cycles));
    end
  end

  initial begin
    audio_clk    = 1'b0;
    arst_n       = 1'b0;
    out_sel      = SEL_RAW;
    delay_length = 8'd0;
    spk_en       = 1'b1;
    test_err     = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    pin_err      = 0;
    aborted      = 1'b0;
    void'($urandom(32'h9f2b6533));
    fill_stream(0, 7, 0, 65536);
    fill_stream(8, 39, 1000, 128);  // Offset plus small variation
    fill_stream(40, 278, 0, 65536);
    fill_stream(279, 1023, 12345, 1);
    apply_reset();
    run_segment("raw_capture", SEL_RAW, 0, 8);
    run_segment("dc_removal", SEL_COND, 0, 32);
    run_segment("delay_0", SEL_DELAYED, 0, 8);
    run_segment("delay_1", SEL_DELAYED, 1, 8);
    run_segment("delay_37", SEL_DELAYED, 37, 8);
    run_segment("delay_255", SEL_DELAYED, 255, 200);
    run_segment("echo_mix", SEL_ECHO, 5, 15);
    run_segment("pdm_level", SEL_RAW, 5, 2);
    measure_density("pdm_density", 1'b1, 65536, 12345 + 32768, 2);
    measure_density("pdm_muted", 1'b0, 2000, 0, 0);
    fill_stream(0, 63, 0, 65536);
    apply_reset();
    run_segment("reset_delay_37", SEL_DELAYED, 37, 45);
    test_err = pin_err;
    finish_test("pin_timing");
    $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && !aborted) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
logic/audio_pkg.sv
logic/i2s_mic_rx.sv
logic/mic_conditioner.sv
logic/sample_delay.sv
logic/pdm_modulator.sv
logic/echo_path_top.sv
tb/mic_model.sv
tb/tb_echo_path.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_echo_path -f compile.f -o tb_echo_path
sim_out=$(./obj_dir/tb_echo_path)
echo "$sim_out"
echo "$sim_out" | grep -q "STATUS: PASS"
